// ==== verilog/blas_params.svh ====
`ifndef BLAS_PARAMS_SVH
`define BLAS_PARAMS_SVH

// Execution tiles on the shared memory
`define BLAS_NUM_TILES	2

// Data memory word address width, 64 words
`define BLAS_DMEM_AW	6

// Issue number width, commit window of 8
`define BLAS_ISSUE_W	3

`define BLAS_DW			32

// Host word addresses above the data memory
`define BLAS_ADR_CMD	8'h80
`define BLAS_ADR_STAT	8'h81

`endif

// ==== verilog/pkg_blas.sv ====
`default_nettype none
`include "blas_params.svh"

package pkg_blas;

	//////////////////////////////////////////////////////////////////////
	// Wishbone classic bundles
	typedef struct packed {
		logic					cyc;
		logic					stb;
		logic					we;
		logic	[7:0]			adr;
		logic	[`BLAS_DW-1:0]	dat_w;
	} wb_req_t;

	typedef struct packed {
		logic					ack;
		logic	[`BLAS_DW-1:0]	dat_r;
	} wb_rsp_t;

	//////////////////////////////////////////////////////////////////////
	// Instruction word
	typedef enum logic [3:0] {
		OP_VADD		= 4'h1,
		OP_VCOPY	= 4'h2,
		OP_FILL		= 4'h3
	} opcode_t;

	typedef struct packed {
		opcode_t								op;
		logic	[`BLAS_DMEM_AW-1:0]				len;	// Count minus one
		logic	[`BLAS_DMEM_AW-1:0]				dst;
		logic	[`BLAS_DMEM_AW-1:0]				src;
		logic	[`BLAS_DW-4-3*`BLAS_DMEM_AW-1:0]	rsvd;
	} instr_vec_t;

	// Immediate overlays src and the reserved bits
	typedef struct packed {
		opcode_t								op;
		logic	[`BLAS_DMEM_AW-1:0]				len;
		logic	[`BLAS_DMEM_AW-1:0]				dst;
		logic	[`BLAS_DW-4-2*`BLAS_DMEM_AW-1:0]	imm;
	} instr_scl_t;

	typedef union packed {
		instr_vec_t		vec;
		instr_scl_t		scl;
	} instr_u;

	//////////////////////////////////////////////////////////////////////
	// Issue and completion records
	typedef struct packed {
		logic							valid;
		logic	[`BLAS_NUM_TILES-1:0]	tile;	// One-hot target
		logic	[`BLAS_ISSUE_W-1:0]		no;
		instr_u							instr;
	} issue_t;

	typedef struct packed {
		logic							valid;
		logic	[`BLAS_ISSUE_W-1:0]		no;
	} done_t;

endpackage

`default_nettype wire

// ==== verilog/issue_ctrl.sv ====
`default_nettype none
`include "blas_params.svh"

module issue_ctrl (
	input	logic							clock,
	input	logic							reset,
	input	pkg_blas::wb_req_t				host_req,
	output	pkg_blas::wb_rsp_t				host_rsp,
	output	pkg_blas::wb_req_t				mem_req,
	input	pkg_blas::wb_rsp_t				mem_rsp,
	input	logic	[`BLAS_NUM_TILES-1:0]	tile_busy,
	input	logic							commit_full,
	input	logic	[15:0]					commit_count,
	output	pkg_blas::issue_t				issue
);

	logic							is_mem;
	logic							is_cmd;
	logic							is_stat;
	logic	[`BLAS_NUM_TILES-1:0]	free;
	logic	[`BLAS_NUM_TILES-1:0]	pick;
	logic							host_sel;
	logic							local_go;
	logic							issue_go;

	logic							local_ack;
	logic	[`BLAS_DW-1:0]			local_dat;
	logic							issue_valid;
	logic	[`BLAS_NUM_TILES-1:0]	issue_tile;
	logic	[`BLAS_ISSUE_W-1:0]		issue_no;
	logic	[`BLAS_ISSUE_W-1:0]		next_no;
	pkg_blas::instr_u				issue_instr;

	always_comb begin
		is_mem		= !host_req.adr[7];
		is_cmd		= host_req.adr == `BLAS_ADR_CMD;
		is_stat		= host_req.adr == `BLAS_ADR_STAT;
		free		= ~tile_busy;
		pick		= free & (~free + 1'b1);	// Lowest free tile
		host_sel	= host_req.cyc && host_req.stb && !is_mem && !local_ack;
		// Command write stalls until a tile and a window slot are free
		issue_go	= host_sel && is_cmd && host_req.we && |free && !commit_full;
		local_go	= issue_go || (host_sel && !(is_cmd && host_req.we));
	end

	// Data accesses go to arbiter port 0
	always_comb begin
		mem_req			= host_req;
		mem_req.cyc		= host_req.cyc && is_mem;
		mem_req.stb		= host_req.stb && is_mem;
		mem_req.adr		= 8'(host_req.adr[`BLAS_DMEM_AW-1:0]);
		host_rsp.ack	= local_ack || mem_rsp.ack;
		host_rsp.dat_r	= local_ack ? local_dat : mem_rsp.dat_r;
	end

	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			local_ack	<= 1'b0;
			issue_valid	<= 1'b0;
			next_no		<= '0;
		end else begin
			local_ack	<= local_go;
			issue_valid	<= issue_go;
			if (issue_go)
				next_no <= next_no + 1'b1;	// Wraps with the window
		end
	end

	always_ff @(posedge clock) begin
		if (local_go)
			local_dat <= is_stat ? {8'h00, 8'(tile_busy), commit_count} : '0;
		if (issue_go) begin
			issue_tile	<= pick;
			issue_no	<= next_no;
			issue_instr	<= pkg_blas::instr_u'(host_req.dat_w);
		end
	end

	always_comb begin
		issue.valid	= issue_valid;
		issue.tile	= issue_tile;
		issue.no	= issue_no;
		issue.instr	= issue_instr;
	end

endmodule

`default_nettype wire

// ==== verilog/tile_unit.sv ====
`default_nettype none
`include "blas_params.svh"

module tile_unit #(
	parameter int TILE_ID = 0
) (
	input	logic					clock,
	input	logic					reset,
	input	pkg_blas::issue_t		issue,
	output	logic					busy,
	output	pkg_blas::wb_req_t		mem_req,
	input	pkg_blas::wb_rsp_t		mem_rsp,
	output	pkg_blas::done_t		done
);

	typedef enum logic [2:0] {
		IDLE,
		RD_SRC,
		RD_DST,
		WR_DST,
		GAP			// Drops cyc so the arbiter can rotate
	} state_t;

	state_t							state;
	logic							done_valid;
	pkg_blas::instr_u				instr;
	logic	[`BLAS_ISSUE_W-1:0]		no_q;
	logic	[`BLAS_DMEM_AW-1:0]		idx;
	logic	[`BLAS_DW-1:0]			wdata;

	logic							accept;
	logic							last;
	logic	[`BLAS_DMEM_AW-1:0]		elem_src;
	logic	[`BLAS_DMEM_AW-1:0]		elem_dst;

	function automatic state_t first_of(pkg_blas::opcode_t op);
		return (op == pkg_blas::OP_FILL) ? WR_DST : RD_SRC;
	endfunction

	always_comb begin
		accept		= (state == IDLE) && issue.valid && issue.tile[TILE_ID];
		last		= idx == instr.vec.len;
		elem_src	= instr.vec.src + idx;
		elem_dst	= instr.vec.dst + idx;
	end

	//////////////////////////////////////////////////////////////////////
	// Element walk
	always_ff @(posedge clock) begin
		if (reset) begin
			state		<= IDLE;
			done_valid	<= 1'b0;
		end else begin
			done_valid	<= 1'b0;
			case (state)
				IDLE:		if (accept) state <= first_of(issue.instr.vec.op);
				RD_SRC:		if (mem_rsp.ack)
								state <= (instr.vec.op == pkg_blas::OP_VADD) ? RD_DST : WR_DST;
				RD_DST:		if (mem_rsp.ack) state <= WR_DST;
				WR_DST: begin
					if (mem_rsp.ack) begin
						state		<= last ? IDLE : GAP;
						done_valid	<= last;
					end
				end
				GAP:		state <= first_of(instr.vec.op);
				default:	state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			instr	<= issue.instr;
			no_q	<= issue.no;
			idx		<= '0;
			wdata	<= `BLAS_DW'(signed'(issue.instr.scl.imm));	// Fill value
		end
		if (state == RD_SRC && mem_rsp.ack)
			wdata <= mem_rsp.dat_r;
		if (state == RD_DST && mem_rsp.ack)
			wdata <= wdata + mem_rsp.dat_r;
		if (state == WR_DST && mem_rsp.ack)
			idx <= idx + 1'b1;
	end

	// cyc held over one element's transactions
	always_comb begin
		busy			= state != IDLE;
		mem_req.cyc		= state inside {RD_SRC, RD_DST, WR_DST};
		mem_req.stb		= mem_req.cyc;
		mem_req.we		= state == WR_DST;
		mem_req.adr		= 8'((state == RD_SRC) ? elem_src : elem_dst);
		mem_req.dat_w	= wdata;
		done.valid		= done_valid;
		done.no			= no_q;
	end

endmodule

`default_nettype wire

// ==== verilog/dmem_arbiter.sv ====
`default_nettype none

module dmem_arbiter #(
	parameter int NUM_MASTERS = 3
) (
	input	logic									clock,
	input	logic									reset,
	input	pkg_blas::wb_req_t	[NUM_MASTERS-1:0]	m_req,
	output	pkg_blas::wb_rsp_t	[NUM_MASTERS-1:0]	m_rsp,
	output	pkg_blas::wb_req_t						s_req,
	input	pkg_blas::wb_rsp_t						s_rsp
);

	localparam int IW = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

	logic	[IW-1:0]	owner;		// Held grant, doubles as last grant
	logic	[IW-1:0]	nxt;
	logic				locked;
	logic				any_req;
	logic				rearb;

	// Search starts one past the last owner
	always_comb begin : pick
		int idx;
		nxt		= owner;
		any_req	= 1'b0;
		for (int k = 1; k <= NUM_MASTERS; k++) begin
			idx = (int'(owner) + k) % NUM_MASTERS;
			if (!any_req && m_req[idx].cyc) begin
				nxt		= IW'(idx);
				any_req	= 1'b1;
			end
		end
		rearb = !locked || !m_req[owner].cyc;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			locked	<= 1'b0;
			owner	<= '0;
		end else if (rearb) begin
			locked	<= any_req;
			if (any_req)
				owner <= nxt;
		end
	end

	always_comb begin
		s_req = locked ? m_req[owner] : '0;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			m_rsp[i].ack	= locked && (owner == IW'(i)) && s_rsp.ack;
			m_rsp[i].dat_r	= s_rsp.dat_r;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dmem.sv ====
`default_nettype none
`include "blas_params.svh"

module dmem (
	input	logic					clock,
	input	logic					reset,
	input	pkg_blas::wb_req_t		req,
	output	pkg_blas::wb_rsp_t		rsp
);

	logic	[`BLAS_DW-1:0]			mem	[0:(1<<`BLAS_DMEM_AW)-1];
	logic	[`BLAS_DW-1:0]			rdata;
	logic							ack_q;
	logic							hit;

	assign hit = req.cyc && req.stb && !ack_q;	// One access per strobe

	always_ff @(posedge clock) begin
		if (reset)
			ack_q <= 1'b0;
		else
			ack_q <= hit;
	end

	always_ff @(posedge clock) begin
		if (hit) begin
			if (req.we)
				mem[req.adr[`BLAS_DMEM_AW-1:0]] <= req.dat_w;
			else
				rdata <= mem[req.adr[`BLAS_DMEM_AW-1:0]];
		end
	end

	always_comb begin
		rsp.ack		= ack_q;
		rsp.dat_r	= rdata;
	end

endmodule

`default_nettype wire

// ==== verilog/commit_agg.sv ====
`default_nettype none
`include "blas_params.svh"

module commit_agg (
	input	logic										clock,
	input	logic										reset,
	input	pkg_blas::issue_t							issue,
	input	pkg_blas::done_t	[`BLAS_NUM_TILES-1:0]	done,
	output	logic										full,
	output	logic				[15:0]					commit_count
);

	localparam int WIN = 1 << `BLAS_ISSUE_W;

	logic	[WIN-1:0]				outstanding;
	logic	[WIN-1:0]				completed;
	logic	[WIN-1:0]				out_n;
	logic	[WIN-1:0]				cmp_n;
	logic	[`BLAS_ISSUE_W-1:0]		head;
	logic							retire;

	//////////////////////////////////////////////////////////////////////
	// Bitmap update, issue sets outstanding and tiles set completed
	always_comb begin
		retire	= completed[head];	// Oldest one finished
		out_n	= outstanding;
		cmp_n	= completed;
		if (retire) begin
			out_n[head]	= 1'b0;
			cmp_n[head]	= 1'b0;
		end
		if (issue.valid)
			out_n[issue.no] = 1'b1;
		for (int t = 0; t < `BLAS_NUM_TILES; t++) begin
			if (done[t].valid)
				cmp_n[done[t].no] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding		<= '0;
			completed		<= '0;
			head			<= '0;
			commit_count	<= '0;
		end else begin
			outstanding	<= out_n;
			completed	<= cmp_n;
			if (retire) begin
				head			<= head + 1'b1;
				commit_count	<= commit_count + 1'b1;
			end
		end
	end

	assign full = &outstanding;		// Every slot in flight

endmodule

`default_nettype wire

// ==== verilog/blas_engine.sv ====
`default_nettype none
`include "blas_params.svh"

module blas_engine (
	input	logic					clock,
	input	logic					reset,
	input	pkg_blas::wb_req_t		host_req,
	output	pkg_blas::wb_rsp_t		host_rsp
);

	localparam int NT = `BLAS_NUM_TILES;

	// Port 0 is the host path, tiles follow
	pkg_blas::wb_req_t	[NT:0]		m_req;
	pkg_blas::wb_rsp_t	[NT:0]		m_rsp;
	pkg_blas::wb_req_t				s_req;
	pkg_blas::wb_rsp_t				s_rsp;

	pkg_blas::issue_t				issue;
	pkg_blas::done_t	[NT-1:0]	tile_done;
	logic				[NT-1:0]	tile_busy;
	logic							commit_full;
	logic				[15:0]		commit_count;

	issue_ctrl i_issue (
		.clock(			clock			),
		.reset(			reset			),
		.host_req(		host_req		),
		.host_rsp(		host_rsp		),
		.mem_req(		m_req[0]		),
		.mem_rsp(		m_rsp[0]		),
		.tile_busy(		tile_busy		),
		.commit_full(	commit_full		),
		.commit_count(	commit_count	),
		.issue(			issue			)
	);

	for (genvar k = 0; k < NT; k++) begin : g_tile
		tile_unit #(
			.TILE_ID(	k				)
		) i_tile (
			.clock(		clock			),
			.reset(		reset			),
			.issue(		issue			),
			.busy(		tile_busy[k]	),
			.mem_req(	m_req[k+1]		),
			.mem_rsp(	m_rsp[k+1]		),
			.done(		tile_done[k]	)
		);
	end

	dmem_arbiter #(
		.NUM_MASTERS(	NT + 1			)
	) i_arb (
		.clock(			clock			),
		.reset(			reset			),
		.m_req(			m_req			),
		.m_rsp(			m_rsp			),
		.s_req(			s_req			),
		.s_rsp(			s_rsp			)
	);

	dmem i_dmem (
		.clock(			clock			),
		.reset(			reset			),
		.req(			s_req			),
		.rsp(			s_rsp			)
	);

	commit_agg i_commit (
		.clock(			clock			),
		.reset(			reset			),
		.issue(			issue			),
		.done(			tile_done		),
		.full(			commit_full		),
		.commit_count(	commit_count	)
	);

endmodule

`default_nettype wire

// ==== tb/blas_engine_assert.sv ====
`default_nettype none

module blas_engine_assert (
	input	logic					clock,
	input	logic					reset,
	input	pkg_blas::wb_req_t		host_req,
	input	pkg_blas::wb_rsp_t		host_rsp,
	input	pkg_blas::issue_t		issue,
	input	logic					commit_full
);
	timeunit 1ns;
	timeprecision 100ps;

	int		violations = 0;
	logic	seen_stb;		// Host has strobed since reset

	always_ff @(posedge clock) begin
		if (reset)
			seen_stb <= 1'b0;
		else if (host_req.cyc && host_req.stb)
			seen_stb <= 1'b1;
	end

	ack_needs_stb: assert property (@(posedge clock) disable iff (reset)
		host_rsp.ack |-> host_req.stb)
	else begin
		violations++;
		$error("host ack without strobe");
	end

	issue_not_full: assert property (@(posedge clock) disable iff (reset)
		!(issue.valid && commit_full))
	else begin
		violations++;
		$error("issue while commit window full");
	end

	quiet_after_reset: assert property (@(posedge clock) disable iff (reset)
		!seen_stb |-> !host_rsp.ack)
	else begin
		violations++;
		$error("host ack before first strobe");
	end

endmodule

bind blas_engine blas_engine_assert i_assert (
	.clock(			clock			),
	.reset(			reset			),
	.host_req(		host_req		),
	.host_rsp(		host_rsp		),
	.issue(			issue			),
	.commit_full(	commit_full		)
);

`default_nettype wire

// ==== tb/tb_blas_engine.sv ====
`default_nettype none
`include "blas_params.svh"

module tb_blas_engine;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH = 1 << `BLAS_DMEM_AW;
	localparam int MAX_CYCLES = 20000;	// Five tests need roughly 7k cycles

	logic					clock;
	logic					reset;
	pkg_blas::wb_req_t		host_req;
	pkg_blas::wb_rsp_t		host_rsp;

	logic	[31:0]			shadow	[0:DEPTH-1];	// Reference memory
	logic	[31:0]			rng;
	int						cycles;
	int						errors;
	int						checks;
	int						issued;

	blas_engine i_dut (
		.clock(		clock		),
		.reset(		reset		),
		.host_req(	host_req	),
		.host_rsp(	host_rsp	)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped after %0d cycles, the DUT never finished", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// One Wishbone classic cycle, then one idle cycle
	task automatic bus_access(input logic we, input logic [7:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		host_req.cyc	<= 1'b1;
		host_req.stb	<= 1'b1;
		host_req.we		<= we;
		host_req.adr	<= adr;
		host_req.dat_w	<= wdata;
		do
			@(posedge clock);
		while (!host_rsp.ack);
		rdata = host_rsp.dat_r;
		host_req <= '0;
		@(posedge clock);
	endtask

	task automatic expect_word(input int adr, input logic [31:0] got,
			input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns: %s word %0d read %h, expected %h",
				$time, what, adr, got, exp);
		end
	endtask

	task automatic check_memory(input string what);
		logic [31:0] rd;
		for (int a = 0; a < DEPTH; a++) begin
			bus_access(1'b0, 8'(a), '0, rd);
			expect_word(a, rd, shadow[a], what);
		end
	endtask

	// Poll status until every issued instruction has retired
	task automatic wait_commits();
		logic [31:0] stat;
		stat = '0;
		do
			bus_access(1'b0, `BLAS_ADR_STAT, '0, stat);
		while (stat[15:0] != 16'(issued));
		checks++;
		if (stat[31:16] !== 16'h0000) begin	// No tile busy once all retired
			errors++;
			$display("[FAIL] %0t ns: status %h shows busy tiles after the last commit",
				$time, stat);
		end
	endtask

	// Model applied at issue time, regions in flight are disjoint
	task automatic issue_op(input pkg_blas::opcode_t op, input int len, input int dst,
			input int src, input logic [15:0] imm);
		logic [31:0] word;
		logic [31:0] unused;
		if (op == pkg_blas::OP_FILL)
			word = {4'(op), 6'(len), 6'(dst), imm};
		else
			word = {4'(op), 6'(len), 6'(dst), 6'(src), 10'h000};
		for (int i = 0; i <= len; i++) begin
			case (op)
				pkg_blas::OP_FILL:	shadow[(dst + i) % DEPTH] = {{16{imm[15]}}, imm};
				pkg_blas::OP_VCOPY:	shadow[(dst + i) % DEPTH] = shadow[(src + i) % DEPTH];
				default:			shadow[(dst + i) % DEPTH] += shadow[(src + i) % DEPTH];
			endcase
		end
		bus_access(1'b1, `BLAS_ADR_CMD, word, unused);	// Stalls under back-pressure
		issued++;
	endtask

	task automatic report_test(input int n, input string name, input int start);
		$display("Test %0d %s finished with %0d errors", n, name, errors - start);
	endtask

	//////////////////////////////////////////////////////////////////////
	initial begin
		logic	[31:0]		rd;
		int					start;
		int					len;
		int					dst;
		int					src;
		int					half;
		pkg_blas::opcode_t	op;

		rng			= 32'd70;
		errors		= 0;
		checks		= 0;
		issued		= 0;
		reset		= 1'b1;
		host_req	= '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		start = errors;
		for (int a = 0; a < DEPTH; a++) begin
			shadow[a] = next_rand();
			bus_access(1'b1, 8'(a), shadow[a], rd);
		end
		check_memory("round trip");
		report_test(1, "memory round trip", start);

		start = errors;
		for (int n = 0; n < 6; n++) begin
			len = next_rand() % 16;
			dst = next_rand() % (DEPTH - len);
			issue_op(pkg_blas::OP_FILL, len, dst, 0, next_rand() % 65536);
			wait_commits();
			check_memory("fill");
		end
		report_test(2, "scalar fill", start);

		start = errors;
		for (int n = 0; n < 8; n++) begin
			op		= n[0] ? pkg_blas::OP_VADD : pkg_blas::OP_VCOPY;
			len		= next_rand() % 16;
			half	= next_rand() % 2;
			dst		= 32 * half + next_rand() % (32 - len);
			src		= 32 * (1 - half) + next_rand() % (32 - len);
			issue_op(op, len, dst, src, '0);
			wait_commits();
			check_memory(n[0] ? "add" : "copy");
		end
		report_test(3, "vector copy and add", start);

		// Two tiles at once, each in its own quarter pair
		start = errors;
		for (int r = 0; r < 6; r++) begin
			for (int t = 0; t < 2; t++) begin
				op	= next_rand() % 2 ? pkg_blas::OP_VADD : pkg_blas::OP_VCOPY;
				len	= next_rand() % 16;
				dst	= 32 * t + next_rand() % (16 - len);
				src	= 32 * t + 16 + next_rand() % (16 - len);
				issue_op(op, len, dst, src, '0);
			end
			for (int k = 0; k < 4; k++) begin
				src = 16 + 32 * (k % 2) + next_rand() % 16;	// Source words stay fixed
				bus_access(1'b0, 8'(src), '0, rd);
				expect_word(src, rd, shadow[src], "interleaved read");
			end
			wait_commits();	// Pair retires before its regions are reused
		end
		check_memory("concurrent");
		report_test(4, "concurrency", start);

		start = errors;
		for (int k = 0; k < 12; k++) begin
			len = next_rand() % 4;
			if (k % 2 == 0)
				issue_op(pkg_blas::OP_FILL, len, 4 * k, 0, next_rand() % 65536);
			else
				issue_op(pkg_blas::OP_VCOPY, len, 4 * k, 48 + 4 * (k % 4), '0);
		end
		wait_commits();
		check_memory("back-pressure");
		report_test(5, "back-pressure and window", start);

		errors += i_dut.i_assert.violations;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d, issued: %0d",
			checks, errors, i_dut.i_assert.violations, issued);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/pkg_blas.sv
verilog/issue_ctrl.sv
verilog/tile_unit.sv
verilog/dmem_arbiter.sv
verilog/dmem.sv
verilog/commit_agg.sv
verilog/blas_engine.sv
tb/blas_engine_assert.sv
tb/tb_blas_engine.sv

// ==== Bender.yml ====
package:
  name: blas_engine

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pkg_blas.sv
      - verilog/issue_ctrl.sv
      - verilog/tile_unit.sv
      - verilog/dmem_arbiter.sv
      - verilog/dmem.sv
      - verilog/commit_agg.sv
      - verilog/blas_engine.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - tb/blas_engine_assert.sv
      - tb/tb_blas_engine.sv
